// ==== vlog.f ====
src/csr_pkg.sv
src/csr_data.sv
src/vec_config.sv
src/elastic_buffer.sv
src/csr_unit.sv
sim/tb_csr_unit.sv

// ==== Makefile ====
# Verilator build for the CSR unit testbench

TOP = tb_csr_unit
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)
	verilator --lint-only --timing --assert \
		src/csr_pkg.sv src/csr_data.sv src/vec_config.sv \
		src/elastic_buffer.sv src/csr_unit.sv --top-module csr_unit

sim:
	verilator --binary --timing --assert -j 0 -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/tb_csr_unit.sv ====
// ############################
// CSR unit testbench
// Directed and random requests against a
// reference model, with random commit stalls
// ############################

`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit import csr_pkg::*; ();

    localparam int reset_cycles = 8;
    localparam int n_directed   = 103;
    localparam int n_random     = 400;

    typedef struct packed {
        csr_rsp_t rsp;
        logic     cycle_read;
    } exp_t;

    logic     clk;
    logic     reset;
    logic     req_valid;
    logic     req_ready;
    csr_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    csr_rsp_t rsp;

    integer   seed       = 32'hde68_50bb;
    integer   ready_seed = 32'hde68_50bb ^ 32'h0000_ffff;
    exp_t     exp_q [$];
    int       errors;
    int       checks;
    int       held;
    logic     stall_mode;
    uuid_t    next_uuid;
    word_t    last_cycle;

    // Reference copy of the architectural state
    word_t      m_scratch [num_warps];
    logic [7:0] m_fcsr    [num_warps];
    word_t      m_vl      [num_warps];
    vtype_t     m_vtype   [num_warps];
    word_t      m_count;

    csr_addr_t addr_list [9] = '{csr_fcsr, csr_mscratch, csr_mcycle, csr_minstret, csr_vl,
                                 csr_vtype, csr_thread_id, csr_mhartid, 12'h7C0};

    csr_unit dut (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error: %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    function automatic exp_t ref_csr_exec(input csr_req_t r);
        exp_t  e;
        word_t src;
        word_t old;
        word_t nw;
        word_t avl;
        word_t vlmax;
        word_t nv;
        e = '0;
        e.rsp.uuid  = r.uuid;
        e.rsp.wid   = r.wid;
        e.rsp.tmask = r.tmask;
        e.rsp.pc    = r.pc;
        e.rsp.rd    = r.rd;
        e.rsp.wb    = r.wb;
        src = r.use_imm ? word_t'(r.imm) : r.rs1_data[0];
        if (r.op == op_vsetvl || r.op == op_vsetvli || r.op == op_vsetivli) begin
            if (r.op == op_vsetivli) begin
                avl = word_t'(r.rs1);
            end else if (r.rs1 != '0) begin
                avl = r.rs1_data[0];
            end else if (r.rd != '0) begin
                avl = '1;
            end else begin
                avl = m_vl[r.wid];
            end
            case (r.vtype_imm[5:3])
                3'd0:    vlmax = vlmax_sew8;
                3'd1:    vlmax = vlmax_sew16;
                3'd2:    vlmax = vlmax_sew32;
                default: vlmax = vlmax_sew64;
            endcase
            nv = (avl < vlmax) ? avl : vlmax;
            m_vl[r.wid]    = nv;
            m_vtype[r.wid] = r.vtype_imm;
            for (int i = 0; i < num_lanes; i++) begin
                e.rsp.data[i] = nv;
            end
        end else begin
            old = '0;
            case (r.addr)
                csr_mscratch: old = m_scratch[r.wid];
                csr_fcsr:     old = word_t'(m_fcsr[r.wid]);
                csr_minstret: old = m_count;
                csr_vl:       old = m_vl[r.wid];
                csr_vtype:    old = word_t'(m_vtype[r.wid]);
                csr_mcycle:   e.cycle_read = 1'b1;
                default: ;
            endcase
            for (int i = 0; i < num_lanes; i++) begin
                if (r.addr == csr_thread_id) begin
                    e.rsp.data[i] = word_t'(i);
                end else if (r.addr == csr_mhartid) begin
                    e.rsp.data[i] = word_t'(core_id * num_warps * num_lanes
                                            + int'(r.wid) * num_lanes + i);
                end else begin
                    e.rsp.data[i] = old;
                end
            end
            // Only mscratch and fcsr keep what is written
            if (r.op == op_csrrw || src != '0) begin
                case (r.op)
                    op_csrrw: nw = src;
                    op_csrrs: nw = old | src;
                    default:  nw = old & ~src;
                endcase
                if (r.addr == csr_mscratch) begin
                    m_scratch[r.wid] = nw;
                end else if (r.addr == csr_fcsr) begin
                    m_fcsr[r.wid] = nw[7:0];
                end
            end
        end
        m_count = m_count + word_t'(1);
        return e;
    endfunction

    function automatic csr_req_t mk_req(input csr_op_e op, input wid_t wid,
                                        input csr_addr_t addr, input logic use_imm,
                                        input word_t value, input reg_idx_t rs1,
                                        input reg_idx_t rd, input vtype_t vtype);
        csr_req_t r;
        r = '0;
        r.uuid    = next_uuid;
        next_uuid = next_uuid + uuid_t'(1);
        r.wid     = wid;
        r.tmask   = 4'hF;
        r.pc      = 32'h8000_0000 + (word_t'(r.uuid) << 2);
        r.rd      = rd;
        r.wb      = (rd != '0);
        r.op      = op;
        r.addr    = addr;
        r.use_imm = use_imm;
        r.imm     = value[4:0];
        r.rs1     = rs1;
        for (int i = 0; i < num_lanes; i++) begin
            r.rs1_data[i] = value ^ word_t'(i * 32'h0101_0000);
        end
        r.vtype_imm = vtype;
        return r;
    endfunction

    function automatic csr_req_t random_req();
        word_t a;
        word_t b;
        word_t c;
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        return mk_req(csr_op_e'(3'(a % 32'd6)), a[9:8], addr_list[a[15:12] % 4'd9], a[16],
                      b, a[21:17], a[26:22], c[8:0]);
    endfunction

    // Holds the request until the DUT takes it
    task automatic send(input csr_req_t r);
        logic accepted;
        req       = r;
        req_valid = 1'b1;
        accepted  = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready;
            if (accepted) begin
                exp_q.push_back(ref_csr_exec(r));
            end
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    task automatic end_test(input string name, input int errors_before);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
        $display("test %s done, %0d errors", name, errors - errors_before);
    endtask

    always @(posedge clk) begin
        #1;
        if (stall_mode) begin
            rsp_ready = (word_t'($random(ready_seed)) % 32'd3) != 32'd0;
        end else begin
            rsp_ready = 1'b1;
        end
    end

    // Response monitor and occupancy tracking
    always @(negedge clk) begin
        exp_t e;
        if (!reset) begin
            check_value("req_ready", 128'(held < 2), 128'(req_ready));
            check_value("rsp_valid", 128'(held != 0), 128'(rsp_valid));
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected response with uuid %h, nothing was pending", rsp.uuid);
                end else begin
                    e = exp_q.pop_front();
                    check_value("rsp.uuid", 128'(e.rsp.uuid), 128'(rsp.uuid));
                    check_value("rsp.wid", 128'(e.rsp.wid), 128'(rsp.wid));
                    check_value("rsp.tmask", 128'(e.rsp.tmask), 128'(rsp.tmask));
                    check_value("rsp.pc", 128'(e.rsp.pc), 128'(rsp.pc));
                    check_value("rsp.rd", 128'(e.rsp.rd), 128'(rsp.rd));
                    check_value("rsp.wb", 128'(e.rsp.wb), 128'(rsp.wb));
                    if (e.cycle_read) begin
                        if (rsp.data != {num_lanes{rsp.data[0]}} || rsp.data[0] <= last_cycle) begin
                            errors++;
                            $display("mcycle read did not advance, previous %0d now %0d",
                                     last_cycle, rsp.data[0]);
                        end
                        last_cycle = rsp.data[0];
                    end else begin
                        check_value("rsp.data", e.rsp.data, rsp.data);
                    end
                end
            end
            held = held + int'(req_valid && req_ready) - int'(rsp_valid && rsp_ready);
        end
    end

    initial begin
        #((reset_cycles + 50 * (n_directed + n_random)) * 10);
        $display("watchdog expired before all responses came back");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int     e0;
        word_t  v;
        vtype_t vt;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b1;
        reset      = 1'b1;
        stall_mode = 1'b0;
        next_uuid  = '0;
        errors     = 0;
        checks     = 0;
        held       = 0;
        last_cycle = '0;
        m_count    = '0;
        for (int w = 0; w < num_warps; w++) begin
            m_scratch[w] = '0;
            m_fcsr[w]    = '0;
            m_vl[w]      = '0;
            m_vtype[w]   = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        e0 = errors;
        for (int w = 0; w < num_warps; w++) begin
            v = $random(seed);
            send(mk_req(op_csrrw, wid_t'(w), csr_mscratch, 1'b0, v, 5'd1, 5'd2, '0));
            send(mk_req(op_csrrs, wid_t'(w), csr_mscratch, 1'b1, 32'd5 + w, 5'd0, 5'd2, '0));
            send(mk_req(op_csrrc, wid_t'(w), csr_mscratch, 1'b0, 32'h0000_ff00, 5'd3, 5'd2, '0));
            send(mk_req(op_csrrs, wid_t'(w), csr_mscratch, 1'b1, '0, 5'd0, 5'd2, '0));
            send(mk_req(op_csrrc, wid_t'(w), csr_mscratch, 1'b0, '0, 5'd0, 5'd2, '0));
            send(mk_req(op_csrrc, wid_t'(w), csr_mscratch, 1'b1, 32'd17, 5'd0, 5'd2, '0));
            send(mk_req(op_csrrs, wid_t'(w), csr_mscratch, 1'b0, '0, 5'd0, 5'd2, '0));
        end
        end_test("mscratch_rw", e0);

        e0 = errors;
        send(mk_req(op_csrrw, 2'd1, csr_fcsr, 1'b0, 32'hffff_ffa5, 5'd4, 5'd1, '0));
        send(mk_req(op_csrrs, 2'd1, csr_fcsr, 1'b0, '0, 5'd0, 5'd1, '0));
        // A zero write that took effect would pull later mcycle reads back
        send(mk_req(op_csrrw, 2'd0, csr_mcycle, 1'b0, '0, 5'd4, 5'd1, '0));
        send(mk_req(op_csrrw, 2'd0, csr_minstret, 1'b0, 32'h0000_0abc, 5'd4, 5'd1, '0));
        send(mk_req(op_csrrw, 2'd2, csr_vl, 1'b1, 32'd9, 5'd0, 5'd1, '0));
        send(mk_req(op_csrrs, 2'd2, csr_vl, 1'b0, '0, 5'd0, 5'd1, '0));
        send(mk_req(op_csrrw, 2'd3, 12'h7C0, 1'b0, 32'hdead_beef, 5'd6, 5'd1, '0));
        send(mk_req(op_csrrs, 2'd3, 12'h7C0, 1'b0, '0, 5'd0, 5'd1, '0));
        send(mk_req(op_csrrs, 2'd0, csr_mcycle, 1'b0, '0, 5'd0, 5'd1, '0));
        send(mk_req(op_csrrs, 2'd0, csr_mcycle, 1'b0, '0, 5'd0, 5'd1, '0));
        send(mk_req(op_csrrs, 2'd1, csr_minstret, 1'b0, '0, 5'd0, 5'd1, '0));
        end_test("special_csrs", e0);

        e0 = errors;
        for (int w = 0; w < num_warps; w++) begin
            send(mk_req(op_csrrs, wid_t'(w), csr_thread_id, 1'b0, '0, 5'd0, 5'd7, '0));
            send(mk_req(op_csrrw, wid_t'(w), csr_mhartid, 1'b1, 32'd3, 5'd0, 5'd7, '0));
        end
        end_test("lane_ids", e0);

        e0 = errors;
        for (int s = 0; s < 8; s++) begin
            v  = $random(seed);
            vt = {2'b00, v[31], 3'(s), 3'b000};
            send(mk_req(op_vsetvli, wid_t'(s), csr_vl, 1'b0, word_t'(v[5:0]), 5'd5, 5'd1, vt));
            send(mk_req(op_csrrs, wid_t'(s), csr_vl, 1'b0, '0, 5'd0, 5'd1, '0));
            send(mk_req(op_csrrs, wid_t'(s), csr_vtype, 1'b0, '0, 5'd0, 5'd1, '0));
            send(mk_req(op_vsetivli, wid_t'(s), csr_vl, 1'b0, v, v[12:8], 5'd1, vt));
            send(mk_req(op_vsetvl, wid_t'(s), csr_vl, 1'b0, v, 5'd0, 5'd3, vt));
            send(mk_req(op_vsetvli, wid_t'(s + 1), csr_vl, 1'b0, v, 5'd0, 5'd0, vt));
            send(mk_req(op_csrrs, wid_t'(s + 1), csr_vl, 1'b0, '0, 5'd0, 5'd1, '0));
        end
        end_test("vector_config", e0);

        e0 = errors;
        stall_mode = 1'b1;
        repeat (n_random) begin
            v = $random(seed);
            if (v[1:0] == 2'b00) begin
                @(posedge clk);
                #1;
            end
            send(random_req());
        end
        end_test("random_stall", e0);
        stall_mode = 1'b0;

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/csr_unit.sv ====
// ############################
// CSR functional unit
// CSR read/modify/write, thread and hart ids, vector
// length setup, results buffered toward commit
// ############################

`timescale 1ns/1ps
`default_nettype none

module csr_unit import csr_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  logic     req_valid,
    output logic     req_ready,
    input  csr_req_t req,

    output logic     rsp_valid,
    input  logic     rsp_ready,
    output csr_rsp_t rsp
);

    logic       fire;
    logic       is_vset;
    logic       is_rw;
    vset_kind_e kind;
    word_t      src;
    word_t      old_value;
    word_t      write_data;
    logic       write_enable;
    word_t      cur_vl;
    vtype_t     cur_vtype;
    word_t      new_vl;
    lane_data_t read_data;
    csr_rsp_t   rsp_in;

    assign fire = req_valid && req_ready;

    // Op decode
    always_comb begin
        is_vset = 1'b0;
        is_rw   = 1'b0;
        kind    = vs_reg;
        case (req.op)
            op_csrrw: begin
                is_rw = 1'b1;
            end
            op_vsetvl: begin
                is_vset = 1'b1;
                kind    = vs_reg;
            end
            op_vsetvli: begin
                is_vset = 1'b1;
                kind    = vs_imm_type;
            end
            op_vsetivli: begin
                is_vset = 1'b1;
                kind    = vs_imm_all;
            end
            default: ;
        endcase
    end

    assign src = req.use_imm ? word_t'(req.imm) : req.rs1_data[0];

    always_comb begin
        case (req.op)
            op_csrrw: write_data = src;
            op_csrrs: write_data = old_value | src;
            default:  write_data = old_value & ~src;
        endcase
    end

    // Set/clear with a zero source is a pure read
    assign write_enable = fire && !is_vset && (is_rw || (src != '0));

    csr_data u_csr_data (
        .clk          (clk),
        .reset        (reset),
        .fire         (fire),
        .read_wid     (req.wid),
        .read_addr    (req.addr),
        .read_data    (old_value),
        .write_enable (write_enable),
        .write_wid    (req.wid),
        .write_addr   (req.addr),
        .write_data   (write_data)
    );

    // VSETVL has its rs2 vtype forwarded in vtype_imm by execute
    vec_config u_vec_config (
        .clk       (clk),
        .reset     (reset),
        .update    (fire && is_vset),
        .kind      (kind),
        .wid       (req.wid),
        .rs1       (req.rs1),
        .rd        (req.rd),
        .rs1_value (req.rs1_data[0]),
        .rs2_value (word_t'(req.vtype_imm)),
        .vtype_imm (req.vtype_imm),
        .cur_vl    (cur_vl),
        .cur_vtype (cur_vtype),
        .new_vl    (new_vl)
    );

    // Per-lane result
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            if (is_vset) begin
                read_data[i] = new_vl;
            end else begin
                case (req.addr)
                    csr_thread_id: read_data[i] = word_t'(i);
                    csr_mhartid: begin
                        read_data[i] = (word_t'(core_id) << (warp_bits + lane_bits))
                                     + (word_t'(req.wid) << lane_bits)
                                     + word_t'(i);
                    end
                    csr_vl:    read_data[i] = cur_vl;
                    csr_vtype: read_data[i] = word_t'(cur_vtype);
                    default:   read_data[i] = old_value;
                endcase
            end
        end
    end

    always_comb begin
        rsp_in.uuid  = req.uuid;
        rsp_in.wid   = req.wid;
        rsp_in.tmask = req.tmask;
        rsp_in.pc    = req.pc;
        rsp_in.rd    = req.rd;
        rsp_in.wb    = req.wb;
        rsp_in.data  = read_data;
    end

    elastic_buffer u_rsp_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (req_valid),
        .ready_in  (req_ready),
        .data_in   (rsp_in),
        .valid_out (rsp_valid),
        .ready_out (rsp_ready),
        .data_out  (rsp)
    );

    // Execute must hold a stalled request
    a_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        (req_valid && !req_ready) |=> (req_valid && $stable(req))
    ) else $error("request changed while stalled");

endmodule

`default_nettype wire

// ==== src/elastic_buffer.sv ====
// ############################
// Response buffer
// Two-entry valid/ready FIFO in front of commit
// ############################

`timescale 1ns/1ps
`default_nettype none

module elastic_buffer import csr_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     valid_in,
    output logic     ready_in,
    input  csr_rsp_t data_in,
    output logic     valid_out,
    input  logic     ready_out,
    output csr_rsp_t data_out
);

    csr_rsp_t   entries [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign ready_in  = (count != 2'd2);
    assign valid_out = (count != 2'd0);
    assign data_out  = entries[rd_ptr];

    assign push = valid_in && ready_in;
    assign pop  = valid_out && ready_out;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: ;
            endcase
        end
    end

    // A push never lands on an entry still waiting to leave
    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset)
        push |-> (count == 2'd0 || wr_ptr != rd_ptr)
    ) else $error("push into full response buffer");

    a_out_stable: assert property (
        @(posedge clk) disable iff (reset)
        (valid_out && !ready_out) |=> (valid_out && $stable(data_out))
    ) else $error("response changed while stalled");

endmodule

`default_nettype wire

// ==== src/vec_config.sv ====
// ############################
// Vector configuration
// Per-warp vl and vtype, and the vl computed
// for VSETVL / VSETVLI / VSETIVLI
// ############################

`timescale 1ns/1ps
`default_nettype none

module vec_config import csr_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       update,
    input  vset_kind_e kind,
    input  wid_t       wid,
    input  reg_idx_t   rs1,
    input  reg_idx_t   rd,
    input  word_t      rs1_value,
    input  word_t      rs2_value,
    input  vtype_t     vtype_imm,
    output word_t      cur_vl,
    output vtype_t     cur_vtype,
    output word_t      new_vl
);

    word_t  vl_q    [num_warps];
    vtype_t vtype_q [num_warps];
    vtype_t next_vtype;
    word_t  avl;
    word_t  vlmax;

    assign cur_vl    = vl_q[wid];
    assign cur_vtype = vtype_q[wid];

    always_comb begin
        next_vtype = (kind == vs_reg) ? rs2_value[$bits(vtype_t)-1:0] : vtype_imm;

        if (kind == vs_imm_all) begin
            avl = word_t'(rs1);
        end else if (rs1 != '0) begin
            avl = rs1_value;
        end else if (rd != '0) begin
            avl = '1;
        end else begin
            // rs1 = x0, rd = x0 keeps the current vl
            avl = vl_q[wid];
        end
    end

    // LMUL 1 only, so vlmax follows vsew alone
    always_comb begin
        case (next_vtype[5:3])
            3'd0:    vlmax = vlmax_sew8;
            3'd1:    vlmax = vlmax_sew16;
            3'd2:    vlmax = vlmax_sew32;
            default: vlmax = vlmax_sew64;
        endcase
    end

    assign new_vl = (avl < vlmax) ? avl : vlmax;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_warps; w++) begin
                vl_q[w]    <= '0;
                vtype_q[w] <= '0;
            end
        end else if (update) begin
            vl_q[wid]    <= new_vl;
            vtype_q[wid] <= next_vtype;
        end
    end

    for (genvar w = 0; w < num_warps; w++) begin : g_vl_check
        a_vl_bound: assert property (
            @(posedge clk) disable iff (reset)
            vl_q[w] <= vlmax_sew8
        ) else $error("warp %0d vl exceeds vlmax", w);
    end

endmodule

`default_nettype wire

// ==== src/csr_data.sv ====
// ############################
// CSR data store
// Per-warp mscratch and fcsr, plus the cycle and
// retired-request counters, with a combinational read
// ############################

`timescale 1ns/1ps
`default_nettype none

module csr_data import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      fire,

    input  wid_t      read_wid,
    input  csr_addr_t read_addr,
    output word_t     read_data,

    input  logic      write_enable,
    input  wid_t      write_wid,
    input  csr_addr_t write_addr,
    input  word_t     write_data
);

    word_t      mscratch [num_warps];
    logic [7:0] fcsr     [num_warps];
    word_t      mcycle;
    word_t      minstret;

    // Only the writable CSRs, anything else is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_warps; w++) begin
                mscratch[w] <= '0;
                fcsr[w]     <= '0;
            end
        end else if (write_enable) begin
            case (write_addr)
                csr_mscratch: mscratch[write_wid] <= write_data;
                csr_fcsr:     fcsr[write_wid] <= write_data[7:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + word_t'(1);
            if (fire) begin
                minstret <= minstret + word_t'(1);
            end
        end
    end

    always_comb begin
        case (read_addr)
            csr_mscratch: read_data = mscratch[read_wid];
            csr_fcsr:     read_data = word_t'(fcsr[read_wid]);
            csr_mcycle:   read_data = mcycle;
            csr_minstret: read_data = minstret;
            default:      read_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/csr_pkg.sv ====
// ############################
// CSR unit package
// Sizes, CSR addresses, ops and the request/response
// structs shared by the CSR functional unit
// ############################

`default_nettype none

package csr_pkg;

    localparam int unsigned num_warps = 4;
    localparam int unsigned num_lanes = 4;
    localparam int unsigned xlen      = 32;
    localparam int unsigned vlen      = 128;
    localparam int unsigned warp_bits = 2;
    localparam int unsigned lane_bits = 2;
    localparam int unsigned core_id   = 3;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [warp_bits-1:0] wid_t;
    typedef logic [11:0]          csr_addr_t;
    typedef logic [4:0]           reg_idx_t;
    typedef logic [15:0]          uuid_t;
    // vlmul [2:0], vsew [5:3], vta [6], vma [7], vill [8]
    typedef logic [8:0]           vtype_t;
    typedef word_t [num_lanes-1:0] lane_data_t;

    localparam csr_addr_t csr_fcsr      = 12'h003;
    localparam csr_addr_t csr_mscratch  = 12'h340;
    localparam csr_addr_t csr_mcycle    = 12'hB00;
    localparam csr_addr_t csr_minstret  = 12'hB02;
    localparam csr_addr_t csr_vl        = 12'hC20;
    localparam csr_addr_t csr_vtype     = 12'hC21;
    localparam csr_addr_t csr_thread_id = 12'hCC0;
    localparam csr_addr_t csr_mhartid   = 12'hF14;

    // Limits at LMUL 1 for a 128-bit vector register
    localparam word_t vlmax_sew8  = word_t'(vlen / 8);
    localparam word_t vlmax_sew16 = word_t'(vlen / 16);
    localparam word_t vlmax_sew32 = word_t'(vlen / 32);
    localparam word_t vlmax_sew64 = word_t'(vlen / 64);

    typedef enum logic [2:0] {
        op_csrrw,
        op_csrrs,
        op_csrrc,
        op_vsetvl,
        op_vsetvli,
        op_vsetivli
    } csr_op_e;

    typedef enum logic [1:0] {
        vs_reg,
        vs_imm_type,
        vs_imm_all
    } vset_kind_e;

    typedef struct packed {
        uuid_t                uuid;
        wid_t                 wid;
        logic [num_lanes-1:0] tmask;
        word_t                pc;
        reg_idx_t             rd;
        logic                 wb;
        csr_op_e              op;
        csr_addr_t            addr;
        logic                 use_imm;
        logic [4:0]           imm;
        reg_idx_t             rs1;
        lane_data_t           rs1_data;
        vtype_t               vtype_imm;
    } csr_req_t;

    typedef struct packed {
        uuid_t                uuid;
        wid_t                 wid;
        logic [num_lanes-1:0] tmask;
        word_t                pc;
        reg_idx_t             rd;
        logic                 wb;
        lane_data_t           data;
    } csr_rsp_t;

endpackage

`default_nettype wire
